// ==== all.f ====
adc_spi_pkg.sv
adc_conv_pkg.sv
spi_master.sv
adc_cmd_decode.sv
adc_frame_ctrl.sv
adc_result_store.sv
adc_reader_top.sv
adc_slave_model.sv
tb_adc_reader.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the ADC readout testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_adc_reader -f all.f

status=0
out=$(./obj_dir/Vtb_adc_reader 2>&1) || status=$?
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q "Simulation PASSED"; then
	exit 0
fi
echo "simulation did not pass, exit status $status"
exit 1

// ==== tb_adc_reader.sv ====
/*
 * Testbench for the ADC readout top level
 * clock, reset, random requests, expected-sample queue and bank copy
 */
`timescale 1ns/1ps

module tb_adc_reader;
	import adc_spi_pkg::*;
	import adc_conv_pkg::*;

	localparam int wait_limit = 20000;			// cycles allowed per wait

	logic			sys_clk = 1'b0;
	logic			sys_rst_n;
	clk_div_t		clk_div;
	logic			conv_req;
	logic			conv_scan;
	adc_chan_t		conv_chan;
	adc_chan_t		rd_chan;
	logic			spi_miso;
	logic			busy;
	logic			spi_cs_n;
	logic			spi_sclk;
	logic			spi_mosi;
	logic			sample_valid;
	adc_chan_t		sample_chan;
	adc_sample_t	sample_data;
	logic			sample_err;
	adc_sample_t	rd_data;
	adc_sample_t	sample_table [8];			// what the adc model returns
	logic			corrupt;
	logic			cmd_ok;
	adc_chan_t		seen_chan;
	adc_chan_t		exp_chan_q [$];				// pending samples, oldest first
	adc_sample_t	exp_data_q [$];
	logic			exp_err_q [$];
	adc_sample_t	bank_copy [8];				// expected result bank
	adc_chan_t		exp_c;
	adc_sample_t	exp_d;
	logic			exp_e;
	adc_chan_t		first_chan;
	integer			seed = 83;

	always #2 sys_clk = ~sys_clk;				// 4 ns period

	adc_reader_top adc_reader_top_inst (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .clk_div(clk_div),
		.conv_req(conv_req), .conv_scan(conv_scan), .conv_chan(conv_chan),
		.spi_miso(spi_miso), .rd_chan(rd_chan), .busy(busy),
		.spi_cs_n(spi_cs_n), .spi_sclk(spi_sclk), .spi_mosi(spi_mosi),
		.sample_valid(sample_valid), .sample_chan(sample_chan),
		.sample_data(sample_data), .sample_err(sample_err), .rd_data(rd_data)
	);

	adc_slave_model adc_slave_model_inst (
		.spi_cs_n(spi_cs_n), .spi_sclk(spi_sclk), .spi_mosi(spi_mosi),
		.spi_miso(spi_miso), .sample_table(sample_table), .corrupt(corrupt),
		.cmd_ok(cmd_ok), .seen_chan(seen_chan)
	);

	task report_mismatch(input string msg);
		$display("ERROR %0t ns: %s", $time, msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task report_timeout(input string what);
		$display("Timed out after %0d cycles waiting for %s", wait_limit, what);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	// every sample pulse must match the oldest pending request
	always @(negedge sys_clk) begin
		if (sys_rst_n && sample_valid) begin
			assert (exp_chan_q.size() > 0)
				else report_mismatch("sample pulse with no conversion pending");
			exp_c = exp_chan_q.pop_front();
			exp_d = exp_data_q.pop_front();
			exp_e = exp_err_q.pop_front();
			assert (sample_chan == exp_c && seen_chan == exp_c && cmd_ok)
				else report_mismatch($sformatf("channel %0d, adc saw %0d, expected %0d",
					sample_chan, seen_chan, exp_c));
			assert (sample_data == exp_d)
				else report_mismatch($sformatf("sample 0x%03h, expected 0x%03h",
					sample_data, exp_d));
			assert (sample_err == exp_e)
				else report_mismatch($sformatf("sample_err %0b, expected %0b", sample_err, exp_e));
			assert (busy == (exp_chan_q.size() > 0))	// busy drops with the last pulse
				else report_mismatch($sformatf("busy %0b at sample pulse", busy));
		end
	end

	task automatic wait_busy(input logic level);
		int n = 0;
		while (busy !== level && n < wait_limit) begin
			@(posedge sys_clk);
			#1;
			n++;
		end
		if (busy !== level)
			report_timeout(level ? "busy to rise" : "busy to fall");
	endtask

	task automatic wait_drained();
		int n = 0;
		while (exp_chan_q.size() > 0 && n < wait_limit) begin
			@(posedge sys_clk);
			#1;
			n++;
		end
		if (exp_chan_q.size() > 0)
			report_timeout("all expected sample pulses");
	endtask

	// new table and divider, then one request pulse
	task automatic start_request(input logic scan, input adc_chan_t chan, input logic bad);
		int last;
		@(posedge sys_clk);
		#1;
		for (int i = 0; i < 8; i++)
			sample_table[3'(i)] = 12'($random(seed));
		clk_div = clk_div_t'($random(seed) & 3);
		corrupt = bad;
		conv_req = 1'b1;
		conv_scan = scan;
		conv_chan = chan;
		last = scan ? int'(adc_last_chan) : int'(chan);
		for (int c = int'(chan); c <= last; c++) begin
			exp_chan_q.push_back(3'(c));
			exp_data_q.push_back(sample_table[3'(c)]);
			exp_err_q.push_back(bad);
			if (!bad)
				bank_copy[3'(c)] = sample_table[3'(c)];	// bad frames leave the bank
		end
		@(posedge sys_clk);
		#1;
		conv_req = 1'b0;
	endtask

	task automatic finish_request();
		wait_busy(1'b1);
		wait_drained();
		wait_busy(1'b0);
	endtask

	task automatic run_request(input logic scan, input adc_chan_t chan, input logic bad);
		start_request(scan, chan, bad);
		finish_request();
	endtask

	task automatic check_bank();
		for (int ch = 0; ch < 8; ch++) begin
			@(posedge sys_clk);
			#1;
			rd_chan = 3'(ch);
			@(negedge sys_clk);
			assert (rd_data == bank_copy[3'(ch)])
				else report_mismatch($sformatf("bank %0d reads 0x%03h, expected 0x%03h",
					ch, rd_data, bank_copy[3'(ch)]));
		end
	endtask

	initial begin
		sys_rst_n = 1'b0;
		clk_div = '0;
		conv_req = 1'b0;
		conv_scan = 1'b0;
		conv_chan = '0;
		rd_chan = '0;
		corrupt = 1'b0;
		for (int i = 0; i < 8; i++) begin
			sample_table[3'(i)] = '0;
			bank_copy[3'(i)] = '0;
		end
		repeat (8) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;
		@(negedge sys_clk);
		assert (spi_cs_n && !busy)
			else report_mismatch($sformatf("after reset cs_n %0b busy %0b", spi_cs_n, busy));
		assert (spi_sclk == spi_cpol)
			else report_mismatch($sformatf("sclk idles at %0b", spi_sclk));
		check_bank();							// all zero after reset

		first_chan = 3'($random(seed));
		run_request(1'b0, first_chan, 1'b0);	// single conversion
		run_request(1'b1, 3'($random(seed)), 1'b0);	// scan to channel 7

		start_request(1'b1, 3'($random(seed)), 1'b0);
		wait_busy(1'b1);
		conv_req = 1'b1;						// arrives while busy, must vanish
		conv_scan = 1'($random(seed));
		conv_chan = 3'($random(seed));
		@(posedge sys_clk);
		#1;
		conv_req = 1'b0;
		finish_request();

		run_request(1'b0, first_chan, 1'b1);	// corrupt frame on a written channel
		check_bank();

		repeat (12)
			run_request(1'($random(seed)), 3'($random(seed)), ($random(seed) & 3) == 0);
		corrupt = 1'b0;
		check_bank();

		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== adc_slave_model.sv ====
/*
 * SPI ADC model for the testbench
 * decodes the control byte, answers with a sample from the table
 */
`timescale 1ns/1ps

module adc_slave_model (
	input	logic						spi_cs_n,		// frame select, low active
	input	logic						spi_sclk,		// serial clock from the DUT
	input	logic						spi_mosi,		// control byte in
	output	logic						spi_miso,		// sample bytes out
	input	adc_conv_pkg::adc_sample_t	sample_table [8],	// value per channel
	input	logic						corrupt,		// force a bad high byte
	output	logic						cmd_ok,			// last control byte well formed
	output	adc_conv_pkg::adc_chan_t	seen_chan		// channel it asked for
);
	import adc_spi_pkg::*;
	import adc_conv_pkg::*;

	logic			sample_clk;					// rises where data is sampled
	spi_byte_t		cmd_shift;					// incoming control bits
	spi_byte_t		cmd_now;					// including the bit on mosi
	logic [15:0]	reply;						// high byte then low byte
	logic [15:0]	reply_sh;					// reply being shifted out
	int				rise_cnt;					// sampling edges this frame
	int				fall_cnt;					// drive edges this frame

	assign sample_clk	= spi_sclk ^ spi_cpol ^ spi_cpha;
	assign cmd_now		= {cmd_shift[6:0], spi_mosi};

	always @(posedge sample_clk or posedge spi_cs_n) begin
		if (spi_cs_n) begin
			rise_cnt <= 0;						// frame over
		end else begin
			cmd_shift <= cmd_now;
			if (rise_cnt == 7) begin			// eighth bit of the control byte
				cmd_ok		<= (cmd_now[7:6] == cmd_start) && (cmd_now[2:0] == 3'b000);
				seen_chan	<= cmd_now[5:3];
				reply		<= {corrupt ? 4'hA : 4'h0, sample_table[cmd_now[5:3]]};
			end
			rise_cnt <= rise_cnt + 1;
		end
	end

	// miso changes on the leading edge, half a period before it is sampled
	always @(negedge sample_clk or posedge spi_cs_n) begin
		if (spi_cs_n) begin
			fall_cnt	<= 0;
			spi_miso	<= 1'b0;
		end else begin
			if (fall_cnt == 8) begin			// first bit of the high byte
				spi_miso	<= reply[15];
				reply_sh	<= {reply[14:0], 1'b0};
			end else if (fall_cnt > 8) begin
				spi_miso	<= reply_sh[15];
				reply_sh	<= {reply_sh[14:0], 1'b0};
			end
			fall_cnt <= fall_cnt + 1;
		end
	end

endmodule

// ==== adc_reader_top.sv ====
/*
 * ADC readout top level
 * request decoder, frame controller, SPI engine and result stage
 */
`timescale 1ns/1ps

module adc_reader_top (
	input	logic						sys_clk,		// system clock
	input	logic						sys_rst_n,		// sync reset, active low
	input	adc_spi_pkg::clk_div_t		clk_div,		// sclk half period
	input	logic						conv_req,		// request pulse
	input	logic						conv_scan,		// scan to channel 7
	input	adc_conv_pkg::adc_chan_t	conv_chan,		// channel or scan start
	input	logic						spi_miso,		// adc data out
	input	adc_conv_pkg::adc_chan_t	rd_chan,		// bank select
	output	logic						busy,			// request in progress
	output	logic						spi_cs_n,		// adc chip select
	output	logic						spi_sclk,		// adc clock
	output	logic						spi_mosi,		// adc data in
	output	logic						sample_valid,	// new sample
	output	adc_conv_pkg::adc_chan_t	sample_chan,
	output	adc_conv_pkg::adc_sample_t	sample_data,
	output	logic						sample_err,		// malformed frame
	output	adc_conv_pkg::adc_sample_t	rd_data			// bank read data
);
	import adc_spi_pkg::*;
	import adc_conv_pkg::*;

	logic			cmd_valid;
	spi_byte_t		cmd_byte;
	adc_chan_t		cmd_chan;
	logic			cs_ctrl;					// frame select, low active
	logic			wr_req;
	logic			wr_ack;
	spi_byte_t		data_tx;
	spi_byte_t		data_rx;
	logic			frame_done;
	adc_chan_t		frame_chan;
	spi_byte_t		frame_hi;
	spi_byte_t		frame_lo;

	adc_cmd_decode adc_cmd_decode_inst (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.conv_req(conv_req), .conv_scan(conv_scan), .conv_chan(conv_chan),
		.frame_done(frame_done), .busy(busy),
		.cmd_valid(cmd_valid), .cmd_byte(cmd_byte), .cmd_chan(cmd_chan)
	);

	adc_frame_ctrl adc_frame_ctrl_inst (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.cmd_valid(cmd_valid), .cmd_byte(cmd_byte), .cmd_chan(cmd_chan),
		.wr_ack(wr_ack), .data_rx(data_rx),
		.cs_ctrl(cs_ctrl), .wr_req(wr_req), .data_tx(data_tx),
		.frame_done(frame_done), .frame_chan(frame_chan),
		.frame_hi(frame_hi), .frame_lo(frame_lo)
	);

	spi_master spi_master_inst (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.cs_ctrl(cs_ctrl), .cs(spi_cs_n),		// cs_ctrl already low active
		.sclk(spi_sclk), .mosi(spi_mosi), .miso(spi_miso),
		.clk_div_val(clk_div), .wr_req(wr_req), .wr_ack(wr_ack),
		.data_tx(data_tx), .data_rx(data_rx)
	);

	adc_result_store adc_result_store_inst (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.frame_done(frame_done), .frame_chan(frame_chan),
		.frame_hi(frame_hi), .frame_lo(frame_lo), .rd_chan(rd_chan),
		.sample_valid(sample_valid), .sample_chan(sample_chan),
		.sample_data(sample_data), .sample_err(sample_err), .rd_data(rd_data)
	);

endmodule

// ==== adc_result_store.sv ====
/*
 * Result stage
 * sample assembly and frame check, per-channel result bank
 */
`timescale 1ns/1ps

module adc_result_store (
	input	logic						sys_clk,		// system clock
	input	logic						sys_rst_n,		// sync reset, active low
	input	logic						frame_done,		// frame complete pulse
	input	adc_conv_pkg::adc_chan_t	frame_chan,		// channel of the frame
	input	adc_spi_pkg::spi_byte_t		frame_hi,		// high sample byte
	input	adc_spi_pkg::spi_byte_t		frame_lo,		// low sample byte
	input	adc_conv_pkg::adc_chan_t	rd_chan,		// bank read select
	output	logic						sample_valid,	// new sample pulse
	output	adc_conv_pkg::adc_chan_t	sample_chan,	// its channel
	output	adc_conv_pkg::adc_sample_t	sample_data,	// its value
	output	logic						sample_err,		// malformed frame
	output	adc_conv_pkg::adc_sample_t	rd_data			// bank read data
);
	import adc_conv_pkg::*;

	adc_sample_t	bank [adc_chan_num];		// latest good sample per channel
	adc_sample_t	new_sample;					// assembled from the frame
	logic			new_err;					// high byte upper nibble set

	assign new_sample	= {frame_hi[3:0], frame_lo};
	assign new_err		= |frame_hi[7:4];		// adc returns zeros there
	assign rd_data		= bank[rd_chan];

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			sample_valid <= 1'b0;
		else
			sample_valid <= frame_done;			// one cycle after the frame
	end

	always_ff @(posedge sys_clk) begin
		if (frame_done) begin
			sample_chan	<= frame_chan;
			sample_data	<= new_sample;
			sample_err	<= new_err;
		end
	end

	// bad frames are reported but never stored
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			for (int i = 0; i < adc_chan_num; i++)
				bank[i] <= '0;
		end else if (frame_done && !new_err) begin
			bank[frame_chan] <= new_sample;
		end
	end

endmodule

// ==== adc_frame_ctrl.sv ====
/*
 * Frame controller
 * one chip-select frame per command with a command byte and two read bytes
 */
`timescale 1ns/1ps

module adc_frame_ctrl (
	input	logic						sys_clk,		// system clock
	input	logic						sys_rst_n,		// sync reset, active low
	input	logic						cmd_valid,		// command pulse
	input	adc_spi_pkg::spi_byte_t		cmd_byte,		// control byte to send
	input	adc_conv_pkg::adc_chan_t	cmd_chan,		// channel of this command
	input	logic						wr_ack,			// shift engine done
	input	adc_spi_pkg::spi_byte_t		data_rx,		// byte from shift engine
	output	logic						cs_ctrl,		// chip select, low active
	output	logic						wr_req,			// start one byte
	output	adc_spi_pkg::spi_byte_t		data_tx,		// byte for shift engine
	output	logic						frame_done,		// frame complete pulse
	output	adc_conv_pkg::adc_chan_t	frame_chan,		// channel of the frame
	output	adc_spi_pkg::spi_byte_t		frame_hi,		// second byte received
	output	adc_spi_pkg::spi_byte_t		frame_lo		// third byte received
);
	import adc_spi_pkg::*;
	import adc_conv_pkg::*;

	frame_state_t	state;						// frame state
	logic [1:0]		byte_cnt;					// byte index inside the frame
	spi_byte_t		cmd_reg;					// latched control byte
	logic			last_byte;					// third byte in flight

	assign last_byte	= (byte_cnt == 2'(frame_bytes - 1));
	assign wr_req		= (state == fr_send);
	assign data_tx		= (byte_cnt == 2'd0) ? cmd_reg : '0;	// zeros clock the sample out
	assign frame_done	= (state == fr_release);	// same cycle cs rises

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state		<= fr_idle;
			cs_ctrl		<= 1'b1;
			byte_cnt	<= 2'd0;
		end else begin
			case (state)
				fr_idle: begin
					if (cmd_valid) begin
						cs_ctrl		<= 1'b0;	// select next cycle
						byte_cnt	<= 2'd0;
						state		<= fr_select;
					end
				end
				fr_select:	state <= fr_send;
				fr_send:	state <= fr_wait_ack;
				fr_wait_ack: begin
					if (wr_ack && last_byte) begin
						cs_ctrl	<= 1'b1;
						state	<= fr_release;
					end else if (wr_ack) begin
						byte_cnt	<= byte_cnt + 2'd1;
						state		<= fr_gap;	// engine still in finish
					end
				end
				fr_gap:		state <= fr_send;
				fr_release:	state <= fr_idle;
				default:	state <= fr_idle;
			endcase
		end
	end

	// payload capture
	always_ff @(posedge sys_clk) begin
		if (state == fr_idle && cmd_valid) begin
			cmd_reg		<= cmd_byte;
			frame_chan	<= cmd_chan;
		end
		if (state == fr_wait_ack && wr_ack && byte_cnt == 2'd1)
			frame_hi <= data_rx;
		if (state == fr_wait_ack && wr_ack && last_byte)
			frame_lo <= data_rx;
	end

	// no byte may complete while no frame is open
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		state == fr_idle |-> cs_ctrl && !wr_ack)
		else $error("chip select low or byte ack while frame idle");

endmodule

// ==== adc_cmd_decode.sv ====
/*
 * Request decoder
 * single and scan requests to a sequence of ADC control bytes, busy flag
 */
`timescale 1ns/1ps

module adc_cmd_decode (
	input	logic						sys_clk,		// system clock
	input	logic						sys_rst_n,		// sync reset, active low
	input	logic						conv_req,		// host request pulse
	input	logic						conv_scan,		// 1 = scan up to channel 7
	input	adc_conv_pkg::adc_chan_t	conv_chan,		// single or start channel
	input	logic						frame_done,		// frame controller finished
	output	logic						busy,			// request in progress
	output	logic						cmd_valid,		// control byte pulse
	output	adc_spi_pkg::spi_byte_t		cmd_byte,		// control byte
	output	adc_conv_pkg::adc_chan_t	cmd_chan		// channel of cmd_byte
);
	import adc_conv_pkg::*;

	decode_state_t	state;						// decoder state
	logic			scan_mode;					// latched conv_scan
	adc_chan_t		cur_chan;					// channel being converted
	logic			last_frame;					// nothing left after this one

	assign last_frame	= !scan_mode || (cur_chan == adc_last_chan);
	assign busy			= (state != dec_idle);	// requests dropped while high
	assign cmd_byte		= {cmd_start, cur_chan, 3'b000};
	assign cmd_chan		= cur_chan;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state		<= dec_idle;
			cmd_valid	<= 1'b0;
			scan_mode	<= 1'b0;
			cur_chan	<= '0;
		end else begin
			cmd_valid <= 1'b0;					// pulse by default
			case (state)
				dec_idle: begin
					if (conv_req) begin
						scan_mode	<= conv_scan;
						cur_chan	<= conv_chan;
						cmd_valid	<= 1'b1;
						state		<= dec_issue;
					end
				end
				dec_issue:	state <= dec_wait_done;
				dec_wait_done: begin
					if (frame_done && last_frame) begin
						state <= dec_idle;		// busy drops next cycle
					end else if (frame_done) begin
						cur_chan	<= cur_chan + 3'd1;	// ascending scan
						cmd_valid	<= 1'b1;
						state		<= dec_issue;
					end
				end
				default:	state <= dec_idle;
			endcase
		end
	end

	// a frame_done in the issue cycle would be lost
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		cmd_valid |-> state == dec_issue && !frame_done)
		else $error("cmd_valid outside issue state or with frame_done");

endmodule

// ==== spi_master.sv ====
/*
 * One-byte full-duplex SPI shift engine
 * programmable sclk half period, mode taken from the link package
 */
`timescale 1ns/1ps

module spi_master (
	input	logic					sys_clk,		// system clock
	input	logic					sys_rst_n,		// sync reset, active low
	input	logic					cs_ctrl,		// chip select from frame controller
	output	logic					cs,				// chip select pin
	output	logic					sclk,			// serial clock pin
	output	logic					mosi,			// serial data out
	input	logic					miso,			// serial data in
	input	adc_spi_pkg::clk_div_t	clk_div_val,	// sclk half period divider
	input	logic					wr_req,			// start one byte
	output	logic					wr_ack,			// byte done, data_rx valid
	input	adc_spi_pkg::spi_byte_t	data_tx,		// byte to shift out
	output	adc_spi_pkg::spi_byte_t	data_rx			// byte shifted in
);
	import adc_spi_pkg::*;

	typedef enum logic [2:0] {
		sm_idle,									// waiting for wr_req
		sm_sclk_idle,								// half period wait
		sm_sclk_edge,								// toggle sclk
		sm_last_half,								// hold after the last edge
		sm_ack,										// wr_ack
		sm_finish									// one spare cycle
	} spi_state_t;

	spi_state_t		state;							// engine state
	clk_div_t		cnt_clk;						// half period counter
	logic [4:0]		cnt_edge;						// sclk edges done this byte
	spi_byte_t		mosi_shift;						// outgoing bits
	spi_byte_t		miso_shift;						// incoming bits
	logic			half_done;						// divider expired
	logic			shift_out;						// move next bit onto mosi
	logic			sample_in;						// capture miso

	assign half_done	= (cnt_clk == clk_div_val);
	assign shift_out	= (state == sm_sclk_edge) &&
		(spi_cpha ? (cnt_edge != 5'd0 && !cnt_edge[0]) : cnt_edge[0]);
	assign sample_in	= (state == sm_sclk_edge) &&
		(spi_cpha ? cnt_edge[0] : !cnt_edge[0]);

	assign cs			= cs_ctrl;					// pin follows controller
	assign mosi			= mosi_shift[7];			// msb first
	assign data_rx		= miso_shift;
	assign wr_ack		= (state == sm_ack);

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state <= sm_idle;
		end else begin
			case (state)
				sm_idle: begin
					if (wr_req)
						state <= sm_sclk_idle;
				end
				sm_sclk_idle: begin
					if (half_done)
						state <= sm_sclk_edge;
				end
				sm_sclk_edge: begin
					if (cnt_edge == 5'(spi_edges - 1))	// last of 16 edges
						state <= sm_last_half;
					else
						state <= sm_sclk_idle;
				end
				sm_last_half: begin
					if (half_done)
						state <= sm_ack;
				end
				sm_ack:		state <= sm_finish;
				sm_finish:	state <= sm_idle;
				default:	state <= sm_idle;
			endcase
		end
	end

	// half period counter runs only in the wait states
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			cnt_clk <= '0;
		else if (state == sm_sclk_idle || state == sm_last_half)
			cnt_clk <= cnt_clk + 16'd1;
		else
			cnt_clk <= '0;
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			cnt_edge <= 5'd0;
		else if (state == sm_idle)
			cnt_edge <= 5'd0;						// new byte
		else if (state == sm_sclk_edge)
			cnt_edge <= cnt_edge + 5'd1;
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			sclk <= spi_cpol;
		else if (state == sm_idle)
			sclk <= spi_cpol;						// park at idle level
		else if (state == sm_sclk_edge)
			sclk <= ~sclk;
	end

	// shift registers
	always_ff @(posedge sys_clk) begin
		if (state == sm_idle && wr_req)
			mosi_shift <= data_tx;					// msb out right away
		else if (shift_out)
			mosi_shift <= {mosi_shift[6:0], 1'b0};
		if (sample_in)
			miso_shift <= {miso_shift[6:0], miso};	// same clock as sclk edge
	end

	// ack lasts one cycle and no new byte may start in the finish cycle
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		wr_ack |=> !wr_ack && !wr_req)
		else $error("wr_ack held two cycles or wr_req during finish");

endmodule

// ==== adc_conv_pkg.sv ====
/*
 * ADC conversion definitions
 * channel and sample types, control byte fields, frame length,
 * state encodings for the decoder and the frame controller
 */
package adc_conv_pkg;

	typedef logic [2:0]		adc_chan_t;			// one of eight inputs
	typedef logic [11:0]	adc_sample_t;		// raw conversion result

	// control byte = {start, chan[2:0], 3'b000}
	localparam logic [1:0]	cmd_start = 2'b10;	// start field, top two bits
	localparam adc_chan_t	adc_last_chan = 3'd7;	// scan stops here
	localparam int unsigned	adc_chan_num = 8;	// result bank depth
	localparam int unsigned	frame_bytes = 3;	// cmd, high, low

	// frame controller
	typedef enum logic [2:0] {
		fr_idle,								// cs high, waiting for a command
		fr_select,								// cs just dropped
		fr_send,								// wr_req to the shift engine
		fr_wait_ack,							// byte in flight
		fr_gap,									// engine finishing, back to idle next
		fr_release								// cs high again, frame_done
	} frame_state_t;

	// command decoder
	typedef enum logic [1:0] {
		dec_idle,								// not busy
		dec_issue,								// cmd_valid out
		dec_wait_done							// frame running
	} decode_state_t;

endpackage

// ==== adc_spi_pkg.sv ====
/*
 * SPI link definitions
 * data byte and sclk divider types, bus mode, per-byte edge count
 */
package adc_spi_pkg;

	typedef logic [7:0]		spi_byte_t;			// one shifted byte, msb first
	typedef logic [15:0]	clk_div_t;			// half period = value + 2 sys clocks

	// mode 3: sclk rests high, adc drives on falling edge, master samples on rising
	localparam logic		spi_cpol = 1'b1;	// sclk level while idle
	localparam logic		spi_cpha = 1'b1;	// sample on trailing edge

	localparam int unsigned	spi_byte_bits = 8;					// bits per transfer
	localparam int unsigned	spi_edges = 2 * spi_byte_bits;		// sclk edges per byte

endpackage
